//--- rtl/csr_pkg.sv
package csr_pkg;

    // machine-mode CSR addresses
    localparam logic [11:0] csr_mstatus   = 12'h300;
    localparam logic [11:0] csr_misa      = 12'h301;
    localparam logic [11:0] csr_mie       = 12'h304;
    localparam logic [11:0] csr_mtvec     = 12'h305;
    localparam logic [11:0] csr_mscratch  = 12'h340;
    localparam logic [11:0] csr_mepc      = 12'h341;
    localparam logic [11:0] csr_mcause    = 12'h342;
    localparam logic [11:0] csr_mip       = 12'h344;
    localparam logic [11:0] csr_mcycle    = 12'hb00;
    localparam logic [11:0] csr_minstret  = 12'hb02;
    localparam logic [11:0] csr_mvendorid = 12'hf11;
    localparam logic [11:0] csr_marchid   = 12'hf12;
    localparam logic [11:0] csr_mimpid    = 12'hf13;
    localparam logic [11:0] csr_mhartid   = 12'hf14;

    // read-modify-write flavour, same code as funct3[1:0]
    typedef enum logic [1:0] {
        csr_op_none  = 2'd0,
        csr_op_write = 2'd1,
        csr_op_set   = 2'd2,
        csr_op_clear = 2'd3
    } csr_op_e;

    // mcause codes, interrupt flag sits at XLEN-1
    localparam int unsigned cause_ecall      = 11;
    localparam int unsigned cause_ebreak     = 3;
    localparam int unsigned cause_timer_code = 7;

    // field positions
    localparam int unsigned mstatus_mie    = 3;
    localparam int unsigned mstatus_mpie   = 7;
    localparam int unsigned mstatus_mpp_lo = 11;
    localparam int unsigned mip_mtip       = 7;

    // SYSTEM instruction encoding
    localparam logic [6:0]  opcode_system  = 7'b1110011;
    localparam logic [2:0]  funct3_priv    = 3'b000;
    localparam logic [11:0] funct12_ecall  = 12'h000;
    localparam logic [11:0] funct12_ebreak = 12'h001;
    localparam logic [11:0] funct12_mret   = 12'h302;

endpackage

//--- rtl/csr_decode.sv
`timescale 1ns/100ps

module csr_decode #(
    parameter int XLEN = 64
) (
    input  logic [31:0]                             inst_i,
    output logic [$bits(csr_pkg::csr_mstatus)-1:0]  csr_index_o,
    output csr_pkg::csr_op_e                        csr_op_o,
    output logic                                    csr_src_o,
    output logic [XLEN-1:0]                         zimm_o,
    output logic                                    inst_ecall_o,
    output logic                                    inst_ebreak_o,
    output logic                                    inst_mret_o
);

    logic        is_system;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic [4:0]  rs1_field;

    assign is_system = inst_i[6:0] == csr_pkg::opcode_system;
    assign funct3    = inst_i[14:12];
    assign funct12   = inst_i[31:20];
    assign rs1_field = inst_i[19:15];

    // uimm form uses the rs1 slot
    assign zimm_o = {{(XLEN-5){1'b0}}, rs1_field};

    always_comb begin
        csr_index_o   = '0;
        csr_op_o      = csr_pkg::csr_op_none;
        csr_src_o     = 1'b0;
        inst_ecall_o  = 1'b0;
        inst_ebreak_o = 1'b0;
        inst_mret_o   = 1'b0;

        if (is_system) begin
            if (funct3 == csr_pkg::funct3_priv) begin
                case (funct12)
                    csr_pkg::funct12_ecall: begin
                        inst_ecall_o = 1'b1;
                    end
                    csr_pkg::funct12_ebreak: begin
                        inst_ebreak_o = 1'b1;
                    end
                    csr_pkg::funct12_mret: begin
                        inst_mret_o = 1'b1;
                    end
                    default: begin
                        inst_mret_o = 1'b0;
                    end
                endcase
            end else begin
                csr_index_o = funct12;
                // funct3[2] picks the immediate source
                csr_src_o   = funct3[2];
                case (funct3[1:0])
                    2'b01: begin
                        csr_op_o = csr_pkg::csr_op_write;
                    end
                    2'b10: begin
                        csr_op_o = csr_pkg::csr_op_set;
                    end
                    2'b11: begin
                        csr_op_o = csr_pkg::csr_op_clear;
                    end
                    default: begin
                        csr_op_o = csr_pkg::csr_op_none;
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/clint_timer.sv
`timescale 1ns/100ps

module clint_timer #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            timecmp_we_i,
    input  logic [XLEN-1:0] timecmp_wdata_i,
    output logic            mtip_o,
    output logic            timer_update_o
);

    logic [XLEN-1:0] mtime_q;
    logic [XLEN-1:0] mtimecmp_q;
    logic [XLEN-1:0] mtimecmp_nxt;
    logic            mtip_q;
    logic            update_q;

    assign mtimecmp_nxt = timecmp_we_i ? timecmp_wdata_i : mtimecmp_q;

    // free running time base
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // all ones keeps the timer quiet out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '1;
        end else begin
            mtimecmp_q <= mtimecmp_nxt;
        end
    end

    // compared against the value being loaded, so the
    // update pulse in the next cycle already sees the new level
    always_ff @(posedge clk) begin
        if (rst) begin
            mtip_q <= 1'b0;
        end else begin
            mtip_q <= mtime_q >= mtimecmp_nxt;
        end
    end

    // one pulse after each mtimecmp write
    always_ff @(posedge clk) begin
        if (rst) begin
            update_q <= 1'b0;
        end else begin
            update_q <= timecmp_we_i;
        end
    end

    assign mtip_o         = mtip_q;
    assign timer_update_o = update_q;

endmodule

//--- rtl/csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile #(
    parameter int XLEN = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid_i,
    input  logic             intp_en_i,
    input  logic [11:0]      csr_index_i,
    input  csr_pkg::csr_op_e csr_op_i,
    input  logic             csr_src_i,
    input  logic [XLEN-1:0]  rs1_data_i,
    input  logic [XLEN-1:0]  zimm_i,
    input  logic [XLEN-1:0]  inst_addr_i,
    input  logic             inst_ecall_i,
    input  logic             inst_ebreak_i,
    input  logic             inst_mret_i,
    input  logic             clint_mtip_i,
    input  logic             clint_update_i,
    output logic             csr_trap_o,
    output logic [XLEN-1:0]  csr_nxt_pc_o,
    output logic [XLEN-1:0]  csr_read_o
);

    localparam int mie_bit  = csr_pkg::mstatus_mie;
    localparam int mpie_bit = csr_pkg::mstatus_mpie;
    localparam int mpp_bit  = csr_pkg::mstatus_mpp_lo;
    localparam int mtip_bit = csr_pkg::mip_mtip;

    // misa for RV64I with MXL of 2
    localparam logic [XLEN-1:0] misa_val    = {2'b10, {(XLEN-28){1'b0}}, 26'h100};
    localparam logic [XLEN-1:0] marchid_val = 1;
    localparam logic [XLEN-1:0] mip_mask    = 1 << mtip_bit;
    localparam logic [XLEN-1:0] cause_timer =
        {1'b1, {(XLEN-1){1'b0}}} | XLEN'(csr_pkg::cause_timer_code);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mip_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mcycle_q;
    logic [XLEN-1:0] minstret_q;

    logic            inst_trap;
    logic            trap_req;
    logic            change_en;
    logic            wr_en;
    logic            trap_en;
    logic            ret_en;
    logic            sd_bit;
    logic [XLEN-1:0] mcycle_nxt;
    logic [XLEN-1:0] minstret_nxt;
    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] csr_cur;
    logic [XLEN-1:0] csr_org;
    logic [XLEN-1:0] csr_nxt;

    assign inst_trap = inst_ecall_i | inst_ebreak_i;
    assign trap_req  = inst_trap | intp_en_i;
    assign change_en = inst_valid_i & ~intp_en_i;
    assign wr_en     = change_en & (csr_op_i != csr_pkg::csr_op_none);
    assign trap_en   = inst_valid_i & trap_req;
    assign ret_en    = inst_valid_i & inst_mret_i;

    assign mcycle_nxt   = mcycle_q + 1'b1;
    assign minstret_nxt = minstret_q + 1'b1;

    always_comb begin
        csr_cur = '0;
        case (csr_index_i)
            csr_pkg::csr_mstatus:   csr_cur = mstatus_q;
            csr_pkg::csr_misa:      csr_cur = misa_val;
            csr_pkg::csr_mie:       csr_cur = mie_q;
            csr_pkg::csr_mtvec:     csr_cur = mtvec_q;
            csr_pkg::csr_mscratch:  csr_cur = mscratch_q;
            csr_pkg::csr_mepc:      csr_cur = mepc_q;
            csr_pkg::csr_mcause:    csr_cur = mcause_q;
            csr_pkg::csr_mip:       csr_cur = mip_q;
            csr_pkg::csr_mcycle:    csr_cur = mcycle_q;
            csr_pkg::csr_minstret:  csr_cur = minstret_q;
            csr_pkg::csr_marchid:   csr_cur = marchid_val;
            // mimpid aliases mstatus
            csr_pkg::csr_mimpid:    csr_cur = mstatus_q;
            default:                csr_cur = '0;
        endcase
    end

    // counters modify on top of this cycle's increment
    assign csr_org = (csr_index_i == csr_pkg::csr_mcycle)   ? mcycle_nxt :
                     (csr_index_i == csr_pkg::csr_minstret) ? minstret_nxt :
                     csr_cur;

    assign operand = csr_src_i ? zimm_i : rs1_data_i;

    always_comb begin
        case (csr_op_i)
            csr_pkg::csr_op_write: csr_nxt = operand;
            csr_pkg::csr_op_set:   csr_nxt = csr_org | operand;
            csr_pkg::csr_op_clear: csr_nxt = csr_org & ~operand;
            default:               csr_nxt = csr_org;
        endcase
    end

    // SD summarizes dirty FS or XS
    assign sd_bit = (csr_nxt[16:15] == 2'b11) | (csr_nxt[14:13] == 2'b11);

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
        end else if (wr_en && csr_index_i == csr_pkg::csr_mstatus) begin
            mstatus_q <= {sd_bit, csr_nxt[XLEN-2:0]};
        end else if (trap_en) begin
            mstatus_q[mpp_bit +: 2] <= 2'b11;
            mstatus_q[mpie_bit]     <= mstatus_q[mie_bit];
            mstatus_q[mie_bit]      <= 1'b0;
        end else if (ret_en) begin
            mstatus_q[mpp_bit +: 2] <= 2'b00;
            mstatus_q[mpie_bit]     <= 1'b1;
            mstatus_q[mie_bit]      <= mstatus_q[mpie_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mie_q      <= '0;
        end else if (wr_en) begin
            // direct mode only
            if (csr_index_i == csr_pkg::csr_mtvec) begin
                mtvec_q <= csr_nxt & ~XLEN'(3);
            end
            if (csr_index_i == csr_pkg::csr_mscratch) begin
                mscratch_q <= csr_nxt;
            end
            if (csr_index_i == csr_pkg::csr_mie) begin
                mie_q <= csr_nxt & mip_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q <= '0;
        end else if (wr_en && csr_index_i == csr_pkg::csr_mepc) begin
            mepc_q <= csr_nxt;
        end else if (trap_en) begin
            mepc_q <= inst_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause_q <= '0;
        end else if (wr_en && csr_index_i == csr_pkg::csr_mcause) begin
            mcause_q <= csr_nxt;
        end else if (trap_en) begin
            if (inst_ecall_i && !intp_en_i) begin
                mcause_q <= XLEN'(csr_pkg::cause_ecall);
            end else if (inst_ebreak_i && !intp_en_i) begin
                mcause_q <= XLEN'(csr_pkg::cause_ebreak);
            end else begin
                mcause_q <= cause_timer;
            end
        end
    end

    // pending bit tracks the timer level
    always_ff @(posedge clk) begin
        if (rst) begin
            mip_q <= '0;
        end else if (wr_en && csr_index_i == csr_pkg::csr_mip) begin
            mip_q <= csr_nxt & mip_mask;
        end else if (clint_mtip_i || clint_update_i) begin
            mip_q[mtip_bit] <= clint_mtip_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q <= '0;
        end else if (wr_en && csr_index_i == csr_pkg::csr_mcycle) begin
            mcycle_q <= csr_nxt;
        end else begin
            mcycle_q <= mcycle_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_q <= '0;
        end else if (wr_en && csr_index_i == csr_pkg::csr_minstret) begin
            minstret_q <= csr_nxt;
        end else if (change_en) begin
            minstret_q <= minstret_nxt;
        end
    end

    assign csr_trap_o   = mstatus_q[mie_bit] & mie_q[mtip_bit] & mip_q[mtip_bit];
    assign csr_nxt_pc_o = trap_en ? mtvec_q : mepc_q;
    assign csr_read_o   = csr_cur;

endmodule

//--- rtl/csr_top.sv
`timescale 1ns/100ps

module csr_top #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid_i,
    input  logic [31:0]     inst_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            intp_en_i,
    input  logic            timecmp_we_i,
    input  logic [XLEN-1:0] timecmp_wdata_i,
    output logic            csr_trap_o,
    output logic [XLEN-1:0] csr_nxt_pc_o,
    output logic [XLEN-1:0] csr_read_o
);

    logic [11:0]      csr_index;
    csr_pkg::csr_op_e csr_op;
    logic             csr_src;
    logic [XLEN-1:0]  zimm;
    logic             inst_ecall;
    logic             inst_ebreak;
    logic             inst_mret;
    logic             mtip;
    logic             timer_update;

    csr_decode #(.XLEN(XLEN)) csr_decode_inst (
        .inst_i        (inst_i),
        .csr_index_o   (csr_index),
        .csr_op_o      (csr_op),
        .csr_src_o     (csr_src),
        .zimm_o        (zimm),
        .inst_ecall_o  (inst_ecall),
        .inst_ebreak_o (inst_ebreak),
        .inst_mret_o   (inst_mret)
    );

    clint_timer #(.XLEN(XLEN)) clint_timer_inst (
        .clk             (clk),
        .rst             (rst),
        .timecmp_we_i    (timecmp_we_i),
        .timecmp_wdata_i (timecmp_wdata_i),
        .mtip_o          (mtip),
        .timer_update_o  (timer_update)
    );

    csr_regfile #(.XLEN(XLEN)) csr_regfile_inst (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .intp_en_i      (intp_en_i),
        .csr_index_i    (csr_index),
        .csr_op_i       (csr_op),
        .csr_src_i      (csr_src),
        .rs1_data_i     (rs1_data_i),
        .zimm_i         (zimm),
        .inst_addr_i    (inst_addr_i),
        .inst_ecall_i   (inst_ecall),
        .inst_ebreak_i  (inst_ebreak),
        .inst_mret_i    (inst_mret),
        .clint_mtip_i   (mtip),
        .clint_update_i (timer_update),
        .csr_trap_o     (csr_trap_o),
        .csr_nxt_pc_o   (csr_nxt_pc_o),
        .csr_read_o     (csr_read_o)
    );

endmodule

//--- sim/csr_checker.sv
`timescale 1ns/100ps

module csr_checker #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid_i,
    input  logic [31:0]     inst_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            intp_en_i,
    input  logic            timecmp_we_i,
    input  logic [XLEN-1:0] timecmp_wdata_i,
    input  logic            csr_trap_i,
    input  logic [XLEN-1:0] csr_nxt_pc_i,
    input  logic [XLEN-1:0] csr_read_i,
    output int              err_count_o,
    output int              check_count_o
);

    localparam int mie_b  = csr_pkg::mstatus_mie;
    localparam int mpie_b = csr_pkg::mstatus_mpie;
    localparam int mpp_b  = csr_pkg::mstatus_mpp_lo;
    localparam int tip_b  = csr_pkg::mip_mtip;

    // MXL=2 and base ISA I
    localparam logic [XLEN-1:0] misa_exp   = (XLEN'(2) << (XLEN-2)) | (XLEN'(1) << 8);
    localparam logic [XLEN-1:0] tip_mask   = XLEN'(1) << tip_b;
    localparam logic [XLEN-1:0] timer_code =
        (XLEN'(1) << (XLEN-1)) | XLEN'(csr_pkg::cause_timer_code);

    logic [XLEN-1:0] m_mstatus;
    logic [XLEN-1:0] m_mtvec;
    logic [XLEN-1:0] m_mepc;
    logic [XLEN-1:0] m_mcause;
    logic [XLEN-1:0] m_mip;
    logic [XLEN-1:0] m_mie;
    logic [XLEN-1:0] m_mscratch;
    logic [XLEN-1:0] m_mcycle;
    logic [XLEN-1:0] m_minstret;
    logic [XLEN-1:0] m_mtime;
    logic [XLEN-1:0] m_mtimecmp;
    logic            m_mtip;
    logic            m_update;
    logic            model_live = 1'b0;
    int              errs = 0;
    int              checks = 0;

    assign err_count_o   = errs;
    assign check_count_o = checks;

    function automatic logic [XLEN-1:0] model_read(input logic [11:0] idx);
        case (idx)
            csr_pkg::csr_mstatus:  return m_mstatus;
            csr_pkg::csr_misa:     return misa_exp;
            csr_pkg::csr_mie:      return m_mie;
            csr_pkg::csr_mtvec:    return m_mtvec;
            csr_pkg::csr_mscratch: return m_mscratch;
            csr_pkg::csr_mepc:     return m_mepc;
            csr_pkg::csr_mcause:   return m_mcause;
            csr_pkg::csr_mip:      return m_mip;
            csr_pkg::csr_mcycle:   return m_mcycle;
            csr_pkg::csr_minstret: return m_minstret;
            csr_pkg::csr_marchid:  return XLEN'(1);
            csr_pkg::csr_mimpid:   return m_mstatus;
            // mvendorid and mhartid read zero
            default:               return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp_v,
                               input logic [XLEN-1:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errs++;
            $display("FAIL %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    always @(posedge clk) begin : model_step
        logic            is_sys;
        logic            is_csr;
        logic            is_priv;
        logic            is_ecall;
        logic            is_ebreak;
        logic            is_mret;
        logic [11:0]     idx;
        logic [1:0]      op;
        logic            take_trap;
        logic            do_write;
        logic            is_ret;
        logic [XLEN-1:0] cur;
        logic [XLEN-1:0] opnd;
        logic [XLEN-1:0] org;
        logic [XLEN-1:0] nxt;
        logic [XLEN-1:0] st;
        logic [XLEN-1:0] cmp_nxt;

        is_sys    = inst_i[6:0] == csr_pkg::opcode_system;
        is_csr    = is_sys && inst_i[14:12] != 3'b000;
        is_priv   = is_sys && inst_i[14:12] == 3'b000;
        is_ecall  = is_priv && inst_i[31:20] == csr_pkg::funct12_ecall;
        is_ebreak = is_priv && inst_i[31:20] == csr_pkg::funct12_ebreak;
        is_mret   = is_priv && inst_i[31:20] == csr_pkg::funct12_mret;
        idx       = is_csr ? inst_i[31:20] : 12'h000;
        op        = is_csr ? inst_i[13:12] : 2'b00;
        cur       = model_read(idx);
        // funct3 bit 2 selects the uimm in the rs1 slot
        opnd      = inst_i[14] ? XLEN'(inst_i[19:15]) : rs1_data_i;
        org       = (idx == csr_pkg::csr_mcycle)   ? m_mcycle + XLEN'(1) :
                    (idx == csr_pkg::csr_minstret) ? m_minstret + XLEN'(1) : cur;
        case (op)
            csr_pkg::csr_op_write: nxt = opnd;
            csr_pkg::csr_op_set:   nxt = org | opnd;
            csr_pkg::csr_op_clear: nxt = org & ~opnd;
            default:               nxt = org;
        endcase
        take_trap = inst_valid_i && (is_ecall || is_ebreak || intp_en_i);
        do_write  = inst_valid_i && !intp_en_i && op != 2'b00;
        is_ret    = inst_valid_i && is_mret;

        if (model_live) begin
            check_value("csr_trap_o", XLEN'(m_mstatus[mie_b] & m_mie[tip_b] & m_mip[tip_b]),
                        XLEN'(csr_trap_i));
            check_value("csr_nxt_pc_o", take_trap ? m_mtvec : m_mepc, csr_nxt_pc_i);
            check_value("csr_read_o", cur, csr_read_i);
        end

        if (rst) begin
            m_mstatus  <= '0;
            m_mtvec    <= '0;
            m_mepc     <= '0;
            m_mcause   <= '0;
            m_mip      <= '0;
            m_mie      <= '0;
            m_mscratch <= '0;
            m_mcycle   <= '0;
            m_minstret <= '0;
            m_mtime    <= '0;
            m_mtimecmp <= '1;
            m_mtip     <= 1'b0;
            m_update   <= 1'b0;
            model_live <= 1'b1;
        end else begin
            st = m_mstatus;
            if (do_write && idx == csr_pkg::csr_mstatus) begin
                st = nxt;
                // SD flags FS or XS dirty
                st[XLEN-1] = (nxt[14:13] == 2'b11) || (nxt[16:15] == 2'b11);
            end else if (take_trap) begin
                st[mpp_b +: 2] = 2'b11;
                st[mpie_b]     = m_mstatus[mie_b];
                st[mie_b]      = 1'b0;
            end else if (is_ret) begin
                st[mpp_b +: 2] = 2'b00;
                st[mpie_b]     = 1'b1;
                st[mie_b]      = m_mstatus[mpie_b];
            end
            m_mstatus <= st;

            if (do_write && idx == csr_pkg::csr_mtvec) begin
                m_mtvec <= nxt & ~XLEN'(3);
            end
            if (do_write && idx == csr_pkg::csr_mscratch) begin
                m_mscratch <= nxt;
            end
            if (do_write && idx == csr_pkg::csr_mie) begin
                m_mie <= nxt & tip_mask;
            end

            if (do_write && idx == csr_pkg::csr_mepc) begin
                m_mepc <= nxt;
            end else if (take_trap) begin
                m_mepc <= inst_addr_i;
            end

            if (do_write && idx == csr_pkg::csr_mcause) begin
                m_mcause <= nxt;
            end else if (take_trap) begin
                m_mcause <= intp_en_i ? timer_code :
                            is_ecall  ? XLEN'(csr_pkg::cause_ecall) :
                                        XLEN'(csr_pkg::cause_ebreak);
            end

            if (do_write && idx == csr_pkg::csr_mip) begin
                m_mip <= nxt & tip_mask;
            end else if (m_mtip || m_update) begin
                m_mip[tip_b] <= m_mtip;
            end

            if (do_write && idx == csr_pkg::csr_mcycle) begin
                m_mcycle <= nxt;
            end else begin
                m_mcycle <= m_mcycle + XLEN'(1);
            end

            if (do_write && idx == csr_pkg::csr_minstret) begin
                m_minstret <= nxt;
            end else if (inst_valid_i && !intp_en_i) begin
                m_minstret <= m_minstret + XLEN'(1);
            end

            // pending compares against the mtimecmp being loaded
            cmp_nxt    = timecmp_we_i ? timecmp_wdata_i : m_mtimecmp;
            m_mtimecmp <= cmp_nxt;
            m_mtime    <= m_mtime + XLEN'(1);
            m_mtip     <= m_mtime >= cmp_nxt;
            m_update   <= timecmp_we_i;
        end
    end

endmodule

//--- sim/csr_tb.sv
`timescale 1ns/100ps

module csr_tb;

    localparam int XLEN         = 64;
    localparam int half_period  = 20;
    localparam int reset_cycles = 10;
    localparam int stim_cycles  = 2000;
    // reset and stimulus with about half again as margin
    localparam int cycle_limit  = reset_cycles + stim_cycles + 990;
    localparam logic [31:0] rand_seed = 32'h3919_1ebb;

    localparam logic [11:0] csr_addrs [14] = '{
        csr_pkg::csr_mstatus, csr_pkg::csr_misa, csr_pkg::csr_mie, csr_pkg::csr_mtvec,
        csr_pkg::csr_mscratch, csr_pkg::csr_mepc, csr_pkg::csr_mcause, csr_pkg::csr_mip,
        csr_pkg::csr_mcycle, csr_pkg::csr_minstret, csr_pkg::csr_mvendorid,
        csr_pkg::csr_marchid, csr_pkg::csr_mimpid, csr_pkg::csr_mhartid
    };

    logic            clk = 1'b0;
    logic            rst;
    logic            inst_valid_i;
    logic [31:0]     inst_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] inst_addr_i;
    logic            intp_en_i;
    logic            timecmp_we_i;
    logic [XLEN-1:0] timecmp_wdata_i;
    logic            csr_trap_o;
    logic [XLEN-1:0] csr_nxt_pc_o;
    logic [XLEN-1:0] csr_read_o;
    int              err_count;
    int              check_count;
    int              cycle_count = 0;

    always #(half_period) clk = ~clk;

    csr_top #(.XLEN(XLEN)) csr_top_inst (
        .clk             (clk),
        .rst             (rst),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .rs1_data_i      (rs1_data_i),
        .inst_addr_i     (inst_addr_i),
        .intp_en_i       (intp_en_i),
        .timecmp_we_i    (timecmp_we_i),
        .timecmp_wdata_i (timecmp_wdata_i),
        .csr_trap_o      (csr_trap_o),
        .csr_nxt_pc_o    (csr_nxt_pc_o),
        .csr_read_o      (csr_read_o)
    );

    csr_checker #(.XLEN(XLEN)) csr_checker_inst (
        .clk             (clk),
        .rst             (rst),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .rs1_data_i      (rs1_data_i),
        .inst_addr_i     (inst_addr_i),
        .intp_en_i       (intp_en_i),
        .timecmp_we_i    (timecmp_we_i),
        .timecmp_wdata_i (timecmp_wdata_i),
        .csr_trap_i      (csr_trap_o),
        .csr_nxt_pc_i    (csr_nxt_pc_o),
        .csr_read_i      (csr_read_o),
        .err_count_o     (err_count),
        .check_count_o   (check_count)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] csr_word(input logic [11:0] addr, input logic [2:0] f3,
                                             input logic [4:0] rs1, input logic [4:0] rd);
        return {addr, rs1, f3, rd, csr_pkg::opcode_system};
    endfunction

    function automatic logic [31:0] priv_word(input logic [11:0] funct12);
        return {funct12, 5'd0, csr_pkg::funct3_priv, 5'd0, csr_pkg::opcode_system};
    endfunction

    task automatic drive_idle();
        inst_valid_i    = 1'b0;
        inst_i          = 32'h0;
        rs1_data_i      = '0;
        inst_addr_i     = '0;
        intp_en_i       = 1'b0;
        timecmp_we_i    = 1'b0;
        timecmp_wdata_i = '0;
    endtask

    // step tracks mtime, which counts from the release of reset
    task automatic drive_random(input int step);
        int          kind;
        logic [2:0]  f3;
        logic [31:0] word;

        kind         = $urandom % 16;
        f3           = 3'(($urandom % 3) + 1);
        f3[2]        = 1'($urandom % 2);
        inst_valid_i = ($urandom % 8) != 0;
        rs1_data_i   = XLEN'({$urandom, $urandom});
        inst_addr_i  = XLEN'({$urandom, $urandom}) & ~XLEN'(3);
        if (kind < 10) begin
            inst_i = csr_word(csr_addrs[$urandom % 14], f3, 5'($urandom), 5'($urandom));
        end else if (kind == 10) begin
            inst_i = priv_word(csr_pkg::funct12_ecall);
        end else if (kind == 11) begin
            inst_i = priv_word(csr_pkg::funct12_ebreak);
        end else if (kind < 14) begin
            inst_i = priv_word(csr_pkg::funct12_mret);
        end else begin
            word      = $urandom;
            word[6:0] = 7'b0110011;
            inst_i    = word;
        end
        // pipeline takes a pending interrupt with the next valid instruction
        intp_en_i       = inst_valid_i & csr_trap_o;
        timecmp_we_i    = ($urandom % 24) == 0;
        timecmp_wdata_i = XLEN'(step) + XLEN'($urandom % 12) - XLEN'(6);
    endtask

    initial begin
        void'($urandom(rand_seed));
        rst = 1'b1;
        drive_idle();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        for (int step = 1; step <= stim_cycles; step++) begin
            @(negedge clk);
            drive_random(step);
        end
        @(negedge clk);
        drive_idle();
        repeat (2) @(negedge clk);
        $display("closing: %0d errors in %0d checks", err_count, check_count);
        if (err_count == 0 && check_count > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- flist.f
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/clint_timer.sv
rtl/csr_regfile.sv
rtl/csr_top.sv
sim/csr_checker.sv
sim/csr_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := csr_tb
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
FAIL_MSG   := FAIL: see errors above
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
